//--- hw/sens_pkg.sv
package sens_pkg;

    parameter int NUM_SENSORS        = 4;       // channels in the subsystem
    parameter int CMD_BYTES          = 6;       // AL, AH, D0..D3

    // command address map
    parameter int SENSOR_GROUP_ADDR  = 'h400;   // subsystem base
    parameter int SENSOR_BASE_INC    = 'h040;   // window per channel
    parameter int SENSOR_CTRL_REL    = 0;       // mode register
    parameter int SENS_STATUS_CTRL_REL = 4;     // status mode + seq number
    parameter int SENS_SYNC_MULT_REL = 6;       // frames to combine minus 1
    parameter int SENS_SYNC_LATE_REL = 7;       // late sync line count
    parameter int SENS_SYNC_LATE_DFLT = 15;     // late count out of reset

    parameter int SENSOR_CHN_EN_BIT  = 8;       // mode reg: channel enable
    parameter int SENSOR_16BIT_BIT   = 9;       // mode reg: 1 = 16 bpp, 0 = 8 bpp

    // status bus addressing
    parameter int STATUS_REG_BASE    = 'h20;    // channel 0
    parameter int STATUS_REG_INC     = 2;       // step per channel

    parameter int SENSOR_DATA_WIDTH  = 12;      // sensor pixel
    parameter int PX_OUT_WIDTH       = 16;      // packed output word

    // one assembled register write, stb is a single cycle
    typedef struct packed {
        logic        stb;
        logic [15:0] addr;
        logic [31:0] data;
    } cmd_wr_t;

    // [15:0] combined frames done, [16] enable, [17] 16-bit, [21:18] combine count
    typedef logic [21:0] status_word_t;
    typedef logic [1:0]  status_seq_t;          // seq number from status ctrl

endpackage

//--- hw/sens_status_if.sv
interface sens_status_if;

    logic                   rq;     // channel has a status word pending
    logic                   start;  // router grant, one cycle
    sens_pkg::status_word_t data;   // held while rq
    sens_pkg::status_seq_t  seq;    // held while rq

    modport channel (
        output rq,
        output data,
        output seq,
        input  start
    );

    modport router (
        input  rq,
        input  data,
        input  seq,
        output start
    );

endinterface

//--- hw/cmd_deser.sv
module cmd_deser (
    input  logic              mclk,
    input  logic              rst_n,
    input  logic [7:0]        cmd_ad_in,  // AL with strobe, then AH, D0..D3
    input  logic              cmd_stb_in, // marks address low byte
    output sens_pkg::cmd_wr_t cmd_wr      // assembled write, stb one cycle
);

    localparam int CNT_W = $clog2(sens_pkg::CMD_BYTES);
    localparam int SR_W  = 8 * sens_pkg::CMD_BYTES;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(sens_pkg::CMD_BYTES - 1);

    logic [CNT_W-1:0] byte_cnt;  // 0 = idle, else bytes already taken
    logic             busy;
    logic             stb_r;
    logic [SR_W-1:0]  sr;        // newest byte enters at the top

    assign busy = (byte_cnt != '0);

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            stb_r    <= 1'b0;
        end else begin
            stb_r <= busy && (byte_cnt == LAST_CNT); // sixth byte this cycle
            if (cmd_stb_in && !busy) begin
                byte_cnt <= CNT_W'(1);
            end else if (busy) begin
                byte_cnt <= (byte_cnt == LAST_CNT) ? '0 : byte_cnt + 1'b1;
            end
        end
    end

    // shift right so AL ends up in the low byte after six shifts
    always_ff @(posedge mclk) begin
        if (cmd_stb_in || busy) begin
            sr <= {cmd_ad_in, sr[SR_W-1:8]};
        end
    end

    assign cmd_wr.stb  = stb_r;
    assign cmd_wr.addr = sr[15:0];      // AH:AL
    assign cmd_wr.data = sr[SR_W-1:16]; // D3..D0, D0 lowest

    // host must not start a new command before the last one is in
    a_no_stb_while_busy : assert property (
        @(posedge mclk) disable iff (!rst_n)
        busy |-> !cmd_stb_in
    ) else $error("cmd_stb_in while collecting command bytes");

endmodule

//--- hw/sensor_channel.sv
module sensor_channel #(
    parameter int SENSOR_NUMBER = 0
) (
    input  logic                                   mclk,
    input  logic                                   rst_n,
    input  sens_pkg::cmd_wr_t                      cmd_wr,     // broadcast write
    input  logic [sens_pkg::SENSOR_DATA_WIDTH-1:0] px_data,
    input  logic                                   px_hact,
    input  logic                                   px_vact,
    output logic [sens_pkg::PX_OUT_WIDTH-1:0]      dout,
    output logic                                   dout_valid,
    output logic                                   last_in_line,
    output logic                                   sof_out,
    output logic                                   eof_out,
    output logic                                   sof_late,
    sens_status_if.channel                         stat
);

    localparam int DW    = sens_pkg::SENSOR_DATA_WIDTH;
    localparam int PAD_W = sens_pkg::PX_OUT_WIDTH - DW;
    localparam logic [15:0] CHN_BASE =
        16'(sens_pkg::SENSOR_GROUP_ADDR + SENSOR_NUMBER * sens_pkg::SENSOR_BASE_INC);

    logic        chn_en, mode16;           // mode register
    logic [1:0]  stat_mode;                // 0 off, 1 single, 3 auto
    sens_pkg::status_seq_t stat_seq;
    logic [7:0]  sync_mult, sync_late;
    logic        wr_ctrl, wr_stat, wr_mult, wr_late;
    logic        hact_d, vact_d, line_end, vact_rise, vact_fall;
    logic        half, dv_r, flush_r;      // half: low byte waiting for a pair
    logic [7:0]  lo_byte;
    logic        in_frame, sof_now, eof_now, late_pend, late_hit;
    logic [7:0]  frm_idx, late_cnt;        // sensor frame in combined, lines since sof
    logic [15:0] frame_cnt;                // combined frames completed
    logic        rq_r, new_rq;
    sens_pkg::status_word_t word_nxt, snap_word;
    sens_pkg::status_seq_t  seq_nxt, snap_seq;

    assign wr_ctrl = cmd_wr.stb && (cmd_wr.addr == CHN_BASE + 16'(sens_pkg::SENSOR_CTRL_REL));
    assign wr_stat = cmd_wr.stb && (cmd_wr.addr == CHN_BASE + 16'(sens_pkg::SENS_STATUS_CTRL_REL));
    assign wr_mult = cmd_wr.stb && (cmd_wr.addr == CHN_BASE + 16'(sens_pkg::SENS_SYNC_MULT_REL));
    assign wr_late = cmd_wr.stb && (cmd_wr.addr == CHN_BASE + 16'(sens_pkg::SENS_SYNC_LATE_REL));

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            chn_en    <= 1'b0;
            mode16    <= 1'b0;
            stat_mode <= 2'b00;
            stat_seq  <= '0;
            sync_mult <= 8'd0;
            sync_late <= 8'(sens_pkg::SENS_SYNC_LATE_DFLT);
        end else begin
            if (wr_ctrl) begin
                chn_en <= cmd_wr.data[sens_pkg::SENSOR_CHN_EN_BIT];
                mode16 <= cmd_wr.data[sens_pkg::SENSOR_16BIT_BIT];
            end
            if (wr_stat) begin
                stat_mode <= cmd_wr.data[1:0];
                stat_seq  <= cmd_wr.data[5:4];
            end
            if (wr_mult) sync_mult <= cmd_wr.data[7:0];
            if (wr_late) sync_late <= cmd_wr.data[7:0];
        end
    end

    assign line_end  = hact_d && !px_hact;
    assign vact_rise = px_vact && !vact_d;
    assign vact_fall = vact_d && !px_vact;

    // pixel packer control
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            dv_r    <= 1'b0;
            flush_r <= 1'b0;
            half    <= 1'b0;
        end else begin
            dv_r    <= 1'b0;
            flush_r <= 1'b0;
            if (chn_en && px_hact) begin
                dv_r <= mode16 || half;         // every pixel, or every pair
                half <= !mode16 && !half;
            end else if (chn_en && half && line_end) begin
                dv_r    <= 1'b1;                // odd line, flush half word
                flush_r <= 1'b1;
                half    <= 1'b0;
            end else if (!chn_en) begin
                half <= 1'b0;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (px_hact && mode16) begin
            dout <= {px_data, {PAD_W{1'b0}}};   // msb aligned
        end else if (px_hact && !half) begin
            lo_byte <= px_data[DW-1 -: 8];      // first of pair
        end else if (px_hact) begin
            dout <= {px_data[DW-1 -: 8], lo_byte};
        end else if (line_end) begin
            dout <= {8'h00, lo_byte};
        end
    end

    assign dout_valid   = dv_r;
    assign last_in_line = dv_r && (flush_r || !px_hact); // hact already low

    // frame combine and late sync
    assign sof_now  = vact_rise && !in_frame && chn_en;
    assign eof_now  = vact_fall && in_frame && (frm_idx >= sync_mult);
    assign late_hit = late_pend &&
                      ((line_end && (late_cnt + 8'd1 >= sync_late)) || eof_now);

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            hact_d    <= 1'b0;
            vact_d    <= 1'b0;
            in_frame  <= 1'b0;
            frm_idx   <= 8'd0;
            frame_cnt <= 16'd0;
            late_pend <= 1'b0;
            late_cnt  <= 8'd0;
            sof_out   <= 1'b0;
            eof_out   <= 1'b0;
            sof_late  <= 1'b0;
        end else begin
            hact_d   <= px_hact;
            vact_d   <= px_vact;
            sof_out  <= sof_now;
            eof_out  <= eof_now;
            sof_late <= late_hit;
            if (sof_now) begin
                in_frame <= 1'b1;
                frm_idx  <= 8'd0;
            end else if (eof_now) begin
                in_frame  <= 1'b0;
                frame_cnt <= frame_cnt + 16'd1;
            end else if (vact_fall && in_frame) begin
                frm_idx <= frm_idx + 8'd1;      // more sensor frames to go
            end
            if (sof_now) begin
                late_pend <= 1'b1;
                late_cnt  <= 8'd0;
            end else if (late_hit) begin
                late_pend <= 1'b0;
            end else if (late_pend && line_end) begin
                late_cnt <= late_cnt + 8'd1;
            end
        end
    end

    // status source, snapshot frozen while rq is up
    assign new_rq   = (wr_stat && cmd_wr.data[1:0] == 2'b01) ||
                      (eof_now && stat_mode == 2'b11);
    assign seq_nxt  = wr_stat ? cmd_wr.data[5:4] : stat_seq;
    assign word_nxt = {sync_mult[3:0], mode16, chn_en, frame_cnt + 16'(eof_now)};

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            rq_r <= 1'b0;
        end else begin
            rq_r <= new_rq || (rq_r && !stat.start);
        end
    end

    always_ff @(posedge mclk) begin
        if (!rq_r || stat.start) begin
            snap_word <= word_nxt;
            snap_seq  <= seq_nxt;
        end
    end

    assign stat.rq   = rq_r;
    assign stat.data = snap_word;
    assign stat.seq  = snap_seq;

    a_no_dv_disabled : assert property (
        @(posedge mclk) disable iff (!rst_n)
        (!chn_en && !$past(chn_en)) |-> !dout_valid
    ) else $error("dout_valid on disabled channel %0d", SENSOR_NUMBER);

    // request and its payload hold until the router grants
    a_rq_hold : assert property (
        @(posedge mclk) disable iff (!rst_n)
        (stat.rq && !stat.start) |=> (stat.rq && $stable(stat.data) && $stable(stat.seq))
    ) else $error("status request dropped before start, channel %0d", SENSOR_NUMBER);

endmodule

//--- hw/status_router.sv
module status_router #(
    parameter int NUM_SENSORS = sens_pkg::NUM_SENSORS
) (
    input  logic          mclk,
    input  logic          rst_n,
    sens_status_if.router stat [NUM_SENSORS],
    output logic [7:0]    status_ad,    // addr, then 3 data bytes
    output logic          status_rq,
    input  logic          status_start  // downstream accepts the packet
);

    localparam int IDX_W = (NUM_SENSORS > 1) ? $clog2(NUM_SENSORS) : 1;

    typedef enum logic [2:0] {S_IDLE, S_START, S_WAIT, S_B1, S_B2, S_B3} state_t;

    state_t                 state;
    logic [NUM_SENSORS-1:0] rq_vec, start_vec;
    sens_pkg::status_word_t data_arr [NUM_SENSORS];
    sens_pkg::status_seq_t  seq_arr  [NUM_SENSORS];
    logic [IDX_W-1:0]       last_idx, next_idx;   // last granted, next winner
    logic                   any_rq;
    sens_pkg::status_word_t word_r;
    sens_pkg::status_seq_t  seq_r;

    for (genvar i = 0; i < NUM_SENSORS; i++) begin : g_port
        assign rq_vec[i]      = stat[i].rq;
        assign data_arr[i]    = stat[i].data;
        assign seq_arr[i]     = stat[i].seq;
        assign stat[i].start  = start_vec[i];
    end

    // round robin, search starts right after the last grant
    always_comb begin
        int unsigned cand;
        any_rq   = 1'b0;
        next_idx = last_idx;
        for (int k = NUM_SENSORS; k >= 1; k--) begin
            cand = (int'(last_idx) + k) % NUM_SENSORS;
            if (rq_vec[cand]) begin
                any_rq   = 1'b1;
                next_idx = IDX_W'(cand);            // smallest offset wins
            end
        end
    end

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            last_idx <= '0;
        end else begin
            case (state)
                S_IDLE: if (any_rq) begin
                    state    <= S_START;
                    last_idx <= next_idx;
                end
                S_START: state <= S_WAIT;
                S_WAIT:  if (status_start) state <= S_B1; // hold byte 0 till accepted
                S_B1:    state <= S_B2;
                S_B2:    state <= S_B3;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (state == S_IDLE && any_rq) begin
            word_r <= data_arr[next_idx];
            seq_r  <= seq_arr[next_idx];
        end
    end

    assign start_vec = (state == S_START) ? NUM_SENSORS'(1) << last_idx : '0;
    assign status_rq = (state == S_WAIT);

    always_comb begin
        case (state)
            S_WAIT:  status_ad = 8'(sens_pkg::STATUS_REG_BASE +
                                    sens_pkg::STATUS_REG_INC * int'(last_idx));
            S_B1:    status_ad = {seq_r, word_r[5:0]};
            S_B2:    status_ad = word_r[13:6];
            S_B3:    status_ad = word_r[21:14];
            default: status_ad = 8'h00;
        endcase
    end

    // single grant, and only to a channel that is asking
    a_one_start : assert property (
        @(posedge mclk) disable iff (!rst_n)
        $onehot0(start_vec) && ((start_vec & rq_vec) == start_vec)
    ) else $error("bad status grant %b for requests %b", start_vec, rq_vec);

    a_ad_hold : assert property (
        @(posedge mclk) disable iff (!rst_n)
        (status_rq && !status_start) |=> (status_rq && $stable(status_ad))
    ) else $error("status_ad changed while waiting for status_start");

endmodule

//--- hw/sensors_top.sv
module sensors_top #(
    parameter int NUM_SENSORS = sens_pkg::NUM_SENSORS
) (
    input  logic                                   mclk,
    input  logic                                   rst_n,
    input  logic [7:0]                             cmd_ad_in,
    input  logic                                   cmd_stb_in,
    output logic [7:0]                             status_ad,
    output logic                                   status_rq,
    input  logic                                   status_start,
    input  logic [sens_pkg::SENSOR_DATA_WIDTH-1:0] px_data [NUM_SENSORS],
    input  logic [NUM_SENSORS-1:0]                 px_hact,
    input  logic [NUM_SENSORS-1:0]                 px_vact,
    output logic [sens_pkg::PX_OUT_WIDTH-1:0]      dout [NUM_SENSORS],
    output logic [NUM_SENSORS-1:0]                 dout_valid,
    output logic [NUM_SENSORS-1:0]                 last_in_line,
    output logic [NUM_SENSORS-1:0]                 sof_out,
    output logic [NUM_SENSORS-1:0]                 eof_out,
    output logic [NUM_SENSORS-1:0]                 sof_late
);

    sens_pkg::cmd_wr_t cmd_wr;                  // same write to every channel
    sens_status_if     stat_if [NUM_SENSORS] ();

    cmd_deser u_cmd_deser (
        .mclk       (mclk),
        .rst_n      (rst_n),
        .cmd_ad_in  (cmd_ad_in),
        .cmd_stb_in (cmd_stb_in),
        .cmd_wr     (cmd_wr)
    );

    for (genvar i = 0; i < NUM_SENSORS; i++) begin : g_chn
        sensor_channel #(
            .SENSOR_NUMBER (i)                  // selects the address window
        ) u_chn (
            .mclk         (mclk),
            .rst_n        (rst_n),
            .cmd_wr       (cmd_wr),
            .px_data      (px_data[i]),
            .px_hact      (px_hact[i]),
            .px_vact      (px_vact[i]),
            .dout         (dout[i]),
            .dout_valid   (dout_valid[i]),
            .last_in_line (last_in_line[i]),
            .sof_out      (sof_out[i]),
            .eof_out      (eof_out[i]),
            .sof_late     (sof_late[i]),
            .stat         (stat_if[i])
        );
    end

    status_router #(
        .NUM_SENSORS (NUM_SENSORS)
    ) u_status_router (
        .mclk         (mclk),
        .rst_n        (rst_n),
        .stat         (stat_if),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

//--- verification/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 16
) (
    output logic mclk,
    output logic rst_n
);

    initial begin
        mclk = 1'b0;
        forever #(PERIOD / 2) mclk = ~mclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge mclk);
        @(negedge mclk);
        rst_n = 1'b1;                          // release away from the active edge
    end

endmodule

//--- verification/tb_sensors.sv
module tb_sensors;

    localparam int NS  = sens_pkg::NUM_SENSORS;
    localparam int TMO = 2000;                 // cycles per wait loop

    logic        mclk, rst_n;
    logic [7:0]  cmd_ad_in, status_ad;
    logic        cmd_stb_in, status_rq, status_start;
    logic [11:0] px_data [NS];
    logic [15:0] dout [NS];
    logic [NS-1:0] px_hact, px_vact, dout_valid, last_in_line, sof_out, eof_out, sof_late;

    logic [31:0] lfsr_state;
    logic [16:0] exp_q [NS][$];                // {last_in_line, word} in output order
    bit          en_m [NS], m16_m [NS], in_frame_m [NS];
    int          mult_m [NS], late_m [NS], sub_m [NS], frames_m [NS];
    int          cnt_sof [NS], cnt_eof [NS], cnt_late [NS], cnt_dv [NS], lines_c [NS];
    int          err_cnt, tests_ok, tests_bad;

    tb_clk_gen u_clk_gen (.mclk(mclk), .rst_n(rst_n));

    sensors_top #(.NUM_SENSORS(NS)) u_sensors_top (
        .mclk(mclk), .rst_n(rst_n), .cmd_ad_in(cmd_ad_in), .cmd_stb_in(cmd_stb_in),
        .status_ad(status_ad), .status_rq(status_rq), .status_start(status_start),
        .px_data(px_data), .px_hact(px_hact), .px_vact(px_vact),
        .dout(dout), .dout_valid(dout_valid), .last_in_line(last_in_line),
        .sof_out(sof_out), .eof_out(eof_out), .sof_late(sof_late)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic int rand_bits(input int n);
        int   r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    // expected words of one line
    function automatic void ref_words(input int ch, input logic [11:0] px [$], input bit m16);
        int n;
        n = px.size();
        for (int i = 0; i < n; i++) begin
            if (m16) begin
                exp_q[ch].push_back({i == n - 1, px[i], 4'h0});     // msb aligned
            end else if (i % 2 == 1) begin
                exp_q[ch].push_back({i == n - 1, px[i][11:4], px[i-1][11:4]});
            end else if (i == n - 1) begin
                exp_q[ch].push_back({1'b1, 8'h00, px[i][11:4]});    // odd tail
            end
        end
    endfunction

    function automatic int exp_sync(input int sensor_frames, input int mult);
        return sensor_frames / (mult + 1);     // combined frames
    endfunction

    function automatic logic [31:0] exp_packet(input int ch, input int seq);
        logic [21:0] w;
        w = {4'(mult_m[ch]), m16_m[ch], en_m[ch], 16'(frames_m[ch])};
        return {8'(sens_pkg::STATUS_REG_BASE + sens_pkg::STATUS_REG_INC * ch),
                2'(seq), w[5:0], w[13:6], w[21:14]};
    endfunction

    function automatic int pending();
        int s;
        s = 0;
        for (int c = 0; c < NS; c++) s += exp_q[c].size();
        return s;
    endfunction

    // one comparing process per channel, samples once the falling-edge inputs settle
    for (genvar c = 0; c < NS; c++) begin : g_cmp
        initial begin : cmp
            logic [16:0] e;
            forever begin
                @(negedge mclk);
                #1;
                if (rst_n) begin
                    if (sof_out[c]) begin
                        cnt_sof[c]++;
                        lines_c[c] = 0;        // late count restarts
                    end
                    if (eof_out[c]) cnt_eof[c]++;
                    if (dout_valid[c]) begin
                        cnt_dv[c]++;
                        if (last_in_line[c]) lines_c[c]++;
                        assert (exp_q[c].size() > 0) else begin
                            $display("channel %0d put out a word with no pixel pending", c);
                            err_cnt++;
                        end
                        if (exp_q[c].size() > 0) begin
                            e = exp_q[c].pop_front();
                            assert ({last_in_line[c], dout[c]} == e) else begin
                                $display("** Error: {last_in_line,dout}[%0d] exp 0x%h got 0x%h",
                                         c, e, {last_in_line[c], dout[c]});
                                err_cnt++;
                            end
                        end
                    end
                    if (sof_late[c]) begin
                        cnt_late[c]++;
                        assert (lines_c[c] == late_m[c] || (eof_out[c] && lines_c[c] < late_m[c]))
                        else begin
                            $display("** Error: sof_late[%0d] lines exp 0x%h got 0x%h",
                                     c, late_m[c], lines_c[c]);
                            err_cnt++;
                        end
                    end
                end
            end
        end
    end

    task automatic write_reg(input int ch, input int rel, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, 16'(sens_pkg::SENSOR_GROUP_ADDR + ch * sens_pkg::SENSOR_BASE_INC + rel)};
        for (int i = 0; i < sens_pkg::CMD_BYTES; i++) begin
            @(negedge mclk);
            cmd_stb_in = (i == 0);             // strobe with address low
            cmd_ad_in  = bytes[8*i +: 8];
        end
        @(negedge mclk);
        cmd_stb_in = 1'b0;
        cmd_ad_in  = 8'h00;
        repeat (3) @(negedge mclk);            // let the write land
    endtask

    task automatic set_mode(input int ch, input bit en, input bit m16);
        write_reg(ch, sens_pkg::SENSOR_CTRL_REL, (32'(en) << 8) | (32'(m16) << 9));
        en_m[ch]  = en;
        m16_m[ch] = m16;
    endtask

    task automatic set_sync(input int ch, input int mult, input int late);
        write_reg(ch, sens_pkg::SENS_SYNC_MULT_REL, 32'(mult));
        write_reg(ch, sens_pkg::SENS_SYNC_LATE_REL, 32'(late));
        mult_m[ch] = mult;
        late_m[ch] = late;
    endtask

    // one sensor frame, len 0 means random line lengths
    task automatic drive_frame(input int ch, input int nlines, input int len);
        logic [11:0] line [$];
        int          n;
        @(negedge mclk);
        px_vact[ch] = 1'b1;
        if (en_m[ch] && !in_frame_m[ch]) begin
            in_frame_m[ch] = 1'b1;             // combined frame starts
            sub_m[ch]      = 0;
        end
        repeat (2) @(negedge mclk);
        for (int l = 0; l < nlines; l++) begin
            n = (len > 0) ? len : 1 + rand_bits(3);
            line.delete();
            for (int k = 0; k < n; k++) line.push_back(12'(rand_bits(12)));
            if (en_m[ch]) ref_words(ch, line, m16_m[ch]);  // queued before driving
            foreach (line[k]) begin
                @(negedge mclk);
                px_hact[ch] = 1'b1;
                px_data[ch] = line[k];
            end
            @(negedge mclk);
            px_hact[ch] = 1'b0;
            @(negedge mclk);                   // line gap
        end
        @(negedge mclk);
        px_vact[ch] = 1'b0;
        if (in_frame_m[ch]) begin
            if (sub_m[ch] == mult_m[ch]) begin
                frames_m[ch]++;
                in_frame_m[ch] = 1'b0;
            end else begin
                sub_m[ch]++;
            end
        end
        repeat (3) @(negedge mclk);
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (pending() > 0 && t < TMO) begin
            @(posedge mclk);
            t++;
        end
        assert (pending() == 0) else begin
            $display("timeout: %0d expected words never came out", pending());
            err_cnt++;
        end
        repeat (4) @(negedge mclk);
    endtask

    task automatic check_val(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("** Error: %s exp 0x%h got 0x%h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic clear_counts();
        for (int c = 0; c < NS; c++) begin
            cnt_sof[c]  = 0;
            cnt_eof[c]  = 0;
            cnt_late[c] = 0;
            cnt_dv[c]   = 0;
        end
    endtask

    // status packet capture, start held off for a random delay
    task automatic get_packet(output logic [31:0] pkt);
        int         t, d;
        logic [7:0] b [4];
        t = 0;
        pkt = '0;
        while (!status_rq && t < TMO) begin
            @(posedge mclk);
            #1;
            t++;
        end
        if (!status_rq) begin
            $display("timeout: no status packet showed up on the status bus");
            err_cnt++;
        end else begin
            b[0] = status_ad;
            d = 1 + rand_bits(3);
            repeat (d) begin
                @(posedge mclk);
                #1;
                check_val("status_ad while waiting", int'(status_ad), int'(b[0]));
                check_val("status_rq while waiting", int'(status_rq), 1);
            end
            @(negedge mclk);
            status_start = 1'b1;
            @(posedge mclk);
            #1;
            b[1] = status_ad;
            check_val("status_rq after status_start", int'(status_rq), 0);
            @(negedge mclk);
            status_start = 1'b0;
            for (int i = 2; i < 4; i++) begin
                @(posedge mclk);
                #1;
                b[i] = status_ad;
            end
            pkt = {b[0], b[1], b[2], b[3]};
        end
    endtask

    task automatic report(input string name, input int e0);
        if (err_cnt == e0) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, err_cnt - e0);
            tests_bad++;
        end
    endtask

    initial begin
        int          e0, t, ch, n_served;
        bit          served [NS];
        logic [31:0] pkt;
        lfsr_state   = 32'h05e0_0c00;
        cmd_ad_in    = 8'h00;
        cmd_stb_in   = 1'b0;
        status_start = 1'b0;
        px_hact      = '0;
        px_vact      = '0;
        err_cnt      = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        for (int c = 0; c < NS; c++) begin
            px_data[c] = '0;
            late_m[c]  = sens_pkg::SENS_SYNC_LATE_DFLT;
            served[c]  = 1'b0;
        end
        t = 0;
        while (rst_n !== 1'b1 && t < 100) begin
            @(posedge mclk);
            t++;
        end
        assert (rst_n === 1'b1) else begin
            $display("reset never released");
            err_cnt++;
        end

        e0 = err_cnt;                          // disabled channel next to an enabled one
        clear_counts();
        set_mode(1, 1'b1, 1'b1);
        drive_frame(0, 3, 6);
        drive_frame(1, 3, 6);
        wait_drain();
        check_val("dout_valid count ch0", cnt_dv[0], 0);
        check_val("sof_out count ch0", cnt_sof[0], 0);
        check_val("eof_out count ch0", cnt_eof[0], 0);
        check_val("sof_out count ch1", cnt_sof[1], 1);
        check_val("eof_out count ch1", cnt_eof[1], 1);
        report("disabled channel", e0);

        e0 = err_cnt;
        drive_frame(1, 4, 0);
        drive_frame(1, 4, 0);
        wait_drain();
        report("16-bit words", e0);

        e0 = err_cnt;
        set_mode(1, 1'b1, 1'b0);
        drive_frame(1, 3, 7);                  // odd lines, half word tail
        drive_frame(1, 2, 4);
        drive_frame(1, 4, 0);
        wait_drain();
        report("8-bit packing", e0);

        e0 = err_cnt;
        clear_counts();
        set_mode(2, 1'b1, 1'b1);
        set_sync(2, 2, 4);                     // late sync inside the frame
        repeat (6) drive_frame(2, 3, 5);
        set_mode(3, 1'b1, 1'b1);
        set_sync(3, 1, 20);                    // eof comes before late count
        repeat (2) drive_frame(3, 3, 4);
        wait_drain();
        check_val("sof_out count ch2", cnt_sof[2], exp_sync(6, 2));
        check_val("eof_out count ch2", cnt_eof[2], exp_sync(6, 2));
        check_val("sof_late count ch2", cnt_late[2], exp_sync(6, 2));
        check_val("sof_out count ch3", cnt_sof[3], exp_sync(2, 1));
        check_val("eof_out count ch3", cnt_eof[3], exp_sync(2, 1));
        check_val("sof_late count ch3", cnt_late[3], exp_sync(2, 1));
        report("frame combine and late sync", e0);

        e0 = err_cnt;
        n_served = 0;
        for (int c = 0; c < NS; c++) begin
            write_reg(c, sens_pkg::SENS_STATUS_CTRL_REL, 32'((((c + 1) & 3) << 4) | 1));
        end
        for (int p = 0; p <= NS; p++) begin
            get_packet(pkt);
            if (p == 0) begin
                // channel 0 asks again while the others are still queued
                write_reg(0, sens_pkg::SENS_STATUS_CTRL_REL, 32'((1 << 4) | 1));
            end
            ch = (int'(pkt[31:24]) - sens_pkg::STATUS_REG_BASE) / sens_pkg::STATUS_REG_INC;
            if (ch < 0 || ch >= NS || served[ch]) begin
                $display("status packet %0d came from a bad or repeated channel", p);
                err_cnt++;
            end else begin
                served[ch] = 1'b1;
                n_served++;
                check_val("status packet", int'(pkt), int'(exp_packet(ch, (ch + 1) & 3)));
            end
            if (n_served == NS) begin
                n_served = 0;                  // every requester served, next round
                for (int c = 0; c < NS; c++) begin
                    served[c] = 1'b0;
                end
            end
        end
        report("status packets", e0);

        $display("%0d tests passed, %0d failed, %0d errors", tests_ok, tests_bad, err_cnt);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- build.f
hw/sens_pkg.sv
hw/sens_status_if.sv
hw/cmd_deser.sv
hw/sensor_channel.sv
hw/status_router.sv
hw/sensors_top.sv
verification/tb_clk_gen.sv
verification/tb_sensors.sv

//--- Makefile
all: build run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_sensors -o Vtb_sensors

run: build
	./obj_dir/Vtb_sensors | tee sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "sim passed" sim.log; then echo "no pass line in log"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -f build.f --top-module tb_sensors

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
